// ==== div_engine.f ====
+incdir+logic
logic/div_types_pkg.sv
logic/div_flow_pkg.sv
logic/credit_fifo.sv
logic/radix2_div.sv
logic/div_dispatch.sv
logic/result_merge.sv
logic/div_engine.sv
tests/div_engine_tb.sv

// ==== logic/credit_fifo.sv ====
`include "div_params.svh"

module credit_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = `DIV_REQ_DEPTH
) (
  input  logic clk,
  input  logic rstn,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output logic out_valid,
  output T     out_data,
  output logic credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign do_pop    = pop && out_valid;
  assign do_push   = push && (count != CNT_W'(DEPTH));

  // each freed slot hands one credit back to the sender.
  assign credit = do_pop;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/div_dispatch.sv ====
`include "div_params.svh"

module div_dispatch (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      q_valid,
  input  div_types_pkg::div_req_t   q_data,
  output logic                      q_pop,
  input  logic [`DIV_LANES-1:0]     lane_ready,
  input  div_flow_pkg::credit_cnt_t merge_room,
  output logic [`DIV_LANES-1:0]     start_vec,
  output div_types_pkg::div_req_t   start_req
);

  logic [`DIV_LANES-1:0]     ready_q;
  logic [`DIV_LANES-1:0]     ready_rise;
  div_flow_pkg::credit_cnt_t inflight;
  div_flow_pkg::credit_cnt_t retire_cnt;
  div_flow_pkg::lane_idx_t   sel;
  logic                      any_ready;
  logic                      go;

  // scanning downward leaves the lowest ready lane selected.
  always_comb begin
    sel       = '0;
    any_ready = 1'b0;
    for (int i = `DIV_LANES - 1; i >= 0; i--) begin
      if (lane_ready[i]) begin
        sel       = div_flow_pkg::lane_idx_t'(i);
        any_ready = 1'b1;
      end
    end
  end

  // a lane whose ready rises has handed its result to the merge.
  assign ready_rise = lane_ready & ~ready_q;

  always_comb begin
    retire_cnt = '0;
    for (int i = 0; i < `DIV_LANES; i++) begin
      retire_cnt = retire_cnt + div_flow_pkg::credit_cnt_t'(ready_rise[i]);
    end
  end

  // every running lane must find a free merge slot when it finishes.
  assign go = q_valid && any_ready && (inflight < merge_room);

  always_comb begin
    start_vec = '0;
    if (go) begin
      start_vec[sel] = 1'b1;
    end
  end

  assign q_pop     = go;
  assign start_req = q_data;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ready_q  <= '1;
      inflight <= '0;
    end else begin
      ready_q  <= lane_ready;
      inflight <= inflight + div_flow_pkg::credit_cnt_t'(go) - retire_cnt;
    end
  end

endmodule

// ==== logic/div_engine.sv ====
`include "div_params.svh"

module div_engine (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    req_valid,
  input  div_types_pkg::div_req_t req,
  output logic                    req_credit,
  output logic                    rsp_valid,
  output div_types_pkg::div_rsp_t rsp,
  input  logic                    rsp_credit
);

  logic                      q_valid;
  logic                      q_pop;
  div_types_pkg::div_req_t   q_data;
  div_types_pkg::div_req_t   start_req;
  logic [`DIV_LANES-1:0]     start_vec;
  logic [`DIV_LANES-1:0]     lane_ready;
  logic [`DIV_LANES-1:0]     lane_done;
  div_types_pkg::div_rsp_t   lane_rsp [`DIV_LANES];
  div_flow_pkg::credit_cnt_t merge_room;

  // ==============================
  // request side
  // ==============================

  credit_fifo #(
    .T     (div_types_pkg::div_req_t),
    .DEPTH (`DIV_REQ_DEPTH)
  ) u_req_q (
    .clk       (clk),
    .rstn      (rstn),
    .push      (req_valid),
    .push_data (req),
    .pop       (q_pop),
    .out_valid (q_valid),
    .out_data  (q_data),
    .credit    (req_credit)
  );

  div_dispatch u_dispatch (
    .clk        (clk),
    .rstn       (rstn),
    .q_valid    (q_valid),
    .q_data     (q_data),
    .q_pop      (q_pop),
    .lane_ready (lane_ready),
    .merge_room (merge_room),
    .start_vec  (start_vec),
    .start_req  (start_req)
  );

  // ==============================
  // lanes and result side
  // ==============================

  for (genvar g = 0; g < `DIV_LANES; g++) begin : g_lane
    radix2_div u_lane (
      .clk   (clk),
      .rstn  (rstn),
      .start (start_vec[g]),
      .req   (start_req),
      .ready (lane_ready[g]),
      .done  (lane_done[g]),
      .rsp   (lane_rsp[g])
    );
  end

  result_merge u_merge (
    .clk        (clk),
    .rstn       (rstn),
    .lane_done  (lane_done),
    .lane_rsp   (lane_rsp),
    .merge_room (merge_room),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

endmodule

// ==== logic/div_flow_pkg.sv ====
`include "div_params.svh"

package div_flow_pkg;

  // the counter must hold the larger of the two depths.
  localparam int CREDIT_MAX = (`DIV_REQ_DEPTH > `DIV_RSP_DEPTH) ?
                              `DIV_REQ_DEPTH : `DIV_RSP_DEPTH;
  localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);
  localparam int LANE_IDX_W = (`DIV_LANES > 1) ? $clog2(`DIV_LANES) : 1;

  typedef logic [CREDIT_W-1:0] credit_cnt_t;

  typedef logic [LANE_IDX_W-1:0] lane_idx_t;

  // sequencer states of one divider lane.
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SUB   = 2'd1,
    SHIFT = 2'd2,
    DONE  = 2'd3
  } lane_state_t;

endpackage

// ==== logic/div_params.svh ====
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// operand width of dividend, divisor, quotient and remainder.
`define DIV_WIDTH 16
// number of identical divider lanes.
`define DIV_LANES 2
// request queue slots, also the upstream credits after reset.
`define DIV_REQ_DEPTH 4
// downstream credits held after reset.
`define DIV_RSP_DEPTH 4
// width of the request id.
`define DIV_ID_W 4

`endif

// ==== logic/div_types_pkg.sv ====
`include "div_params.svh"

package div_types_pkg;

  // ==============================
  // request format
  // ==============================

  // one unsigned division request as it arrives from upstream.
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] dividend;
    logic [`DIV_WIDTH-1:0] divisor;
    logic [`DIV_ID_W-1:0]  id;
  } div_req_t;

  // ==============================
  // response format
  // ==============================

  // dz marks a zero divisor, in which case the quotient is all ones
  // and the remainder is the dividend.
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] quotient;
    logic [`DIV_WIDTH-1:0] remainder;
    logic [`DIV_ID_W-1:0]  id;
    logic                  dz;
  } div_rsp_t;

endpackage

// ==== logic/radix2_div.sv ====
`include "div_params.svh"

module radix2_div (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start,
  input  div_types_pkg::div_req_t req,
  output logic                    ready,
  output logic                    done,
  output div_types_pkg::div_rsp_t rsp
);

  localparam int W     = `DIV_WIDTH;
  localparam int CNT_W = $clog2(W + 1);

  div_flow_pkg::lane_state_t state;
  div_flow_pkg::lane_state_t state_nxt;

  logic [2*W-1:0]       work;
  logic [2*W-1:0]       div_al;
  logic [CNT_W-1:0]     cnt;
  logic [`DIV_ID_W-1:0] id_q;
  logic                 dz_q;
  div_types_pkg::div_rsp_t rsp_q;

  // ==============================
  // sequencer
  // ==============================

  always_comb begin
    state_nxt = state;
    case (state)
      div_flow_pkg::IDLE: begin
        if (start) begin
          state_nxt = div_flow_pkg::SUB;
        end
      end
      div_flow_pkg::SUB: begin
        state_nxt = div_flow_pkg::SHIFT;
      end
      div_flow_pkg::SHIFT: begin
        if (cnt < CNT_W'(W)) begin
          state_nxt = div_flow_pkg::SUB;
        end else begin
          state_nxt = div_flow_pkg::DONE;
        end
      end
      default: begin
        state_nxt = div_flow_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= div_flow_pkg::IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (state == div_flow_pkg::IDLE) begin
        cnt <= '0;
      end else if (state == div_flow_pkg::SHIFT && cnt < CNT_W'(W)) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // ==============================
  // datapath
  // ==============================

  // the dividend starts in the low half and the divisor sits in the high half.
  // with a zero divisor no step subtracts, so the dividend ends up shifted
  // whole into the high half and becomes the remainder.
  always_ff @(posedge clk) begin
    case (state)
      div_flow_pkg::IDLE: begin
        if (start) begin
          work   <= {{W{1'b0}}, req.dividend};
          div_al <= {req.divisor, {W{1'b0}}};
          id_q   <= req.id;
          dz_q   <= (req.divisor == '0);
        end
      end
      div_flow_pkg::SUB: begin
        if (!dz_q && work >= div_al) begin
          work <= work - div_al + 1'b1;
        end
      end
      div_flow_pkg::SHIFT: begin
        if (cnt < CNT_W'(W)) begin
          work <= work << 1;
        end else begin
          rsp_q.quotient  <= dz_q ? {W{1'b1}} : work[W-1:0];
          rsp_q.remainder <= work[2*W-1:W];
          rsp_q.id        <= id_q;
          rsp_q.dz        <= dz_q;
        end
      end
      default: begin
      end
    endcase
  end

  assign ready = (state == div_flow_pkg::IDLE);
  assign done  = (state == div_flow_pkg::DONE);
  assign rsp   = rsp_q;

endmodule

// ==== logic/result_merge.sv ====
`include "div_params.svh"

module result_merge (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [`DIV_LANES-1:0]     lane_done,
  input  div_types_pkg::div_rsp_t   lane_rsp [`DIV_LANES],
  output div_flow_pkg::credit_cnt_t merge_room,
  output logic                      rsp_valid,
  output div_types_pkg::div_rsp_t   rsp,
  input  logic                      rsp_credit
);

  localparam int MERGE_DEPTH = 2;

  logic [`DIV_LANES-1:0]     pend;
  logic [`DIV_LANES-1:0]     pend_all;
  logic [`DIV_LANES-1:0]     pick_vec;
  div_flow_pkg::lane_idx_t   pick;
  logic                      push;
  logic                      fifo_valid;
  div_types_pkg::div_rsp_t   push_data;
  div_flow_pkg::credit_cnt_t occ;
  div_flow_pkg::credit_cnt_t pend_cnt;
  div_flow_pkg::credit_cnt_t credits;

  // ==============================
  // lane collection
  // ==============================

  // a lane keeps its result until its next run completes, so lanes that
  // finish together can wait here and be pushed one per cycle.
  always_comb begin
    pend_all = pend | lane_done;
    pick     = '0;
    push     = 1'b0;
    for (int i = `DIV_LANES - 1; i >= 0; i--) begin
      if (pend_all[i]) begin
        pick = div_flow_pkg::lane_idx_t'(i);
        push = 1'b1;
      end
    end
    pick_vec = '0;
    if (push) begin
      pick_vec[pick] = 1'b1;
    end
  end

  always_comb begin
    pend_cnt = '0;
    for (int i = 0; i < `DIV_LANES; i++) begin
      pend_cnt = pend_cnt + div_flow_pkg::credit_cnt_t'(pend[i]);
    end
  end

  assign push_data  = lane_rsp[pick];
  assign merge_room = div_flow_pkg::credit_cnt_t'(MERGE_DEPTH) - occ - pend_cnt;

  credit_fifo #(
    .T     (div_types_pkg::div_rsp_t),
    .DEPTH (MERGE_DEPTH)
  ) u_rsp_q (
    .clk       (clk),
    .rstn      (rstn),
    .push      (push),
    .push_data (push_data),
    .pop       (rsp_valid),
    .out_valid (fifo_valid),
    .out_data  (rsp),
    .credit    ()
  );

  // ==============================
  // downstream credits
  // ==============================

  assign rsp_valid = fifo_valid && (credits != '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pend    <= '0;
      occ     <= '0;
      credits <= div_flow_pkg::credit_cnt_t'(`DIV_RSP_DEPTH);
    end else begin
      pend    <= pend_all & ~pick_vec;
      occ     <= occ + div_flow_pkg::credit_cnt_t'(push)
                     - div_flow_pkg::credit_cnt_t'(rsp_valid);
      credits <= credits - div_flow_pkg::credit_cnt_t'(rsp_valid)
                         + div_flow_pkg::credit_cnt_t'(rsp_credit);
    end
  end

endmodule

// ==== tests/div_engine_tb.sv ====
`include "div_params.svh"

module div_engine_tb;

  localparam int N     = 16;
  localparam int LAT   = 2 * `DIV_WIDTH + 3;
  localparam int LIMIT = N * (LAT + 20);

  localparam logic [31:0] SEED = 32'hed1132e3;

  // hold is the number of cycles the consumer keeps the credit of this response.
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] dividend;
    logic [`DIV_WIDTH-1:0] divisor;
    logic [7:0]            hold;
  } stim_t;

  logic                    clk;
  logic                    rstn;
  logic                    req_valid;
  div_types_pkg::div_req_t req;
  logic                    req_credit;
  logic                    rsp_valid;
  div_types_pkg::div_rsp_t rsp;
  logic                    rsp_credit;

  stim_t                 stim   [N];
  logic [`DIV_WIDTH-1:0] exp_q  [N];
  logic [`DIV_WIDTH-1:0] exp_r  [N];
  logic                  exp_dz [N];

  int          errors;
  int          sent;
  int          up_returned;
  int          rcvd;
  int          dn_returned;
  int          cycle;
  int          gap;
  int          due_q [$];
  logic [31:0] rng_send;
  logic [31:0] rng_cred;

  div_engine UUT (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic stim_t make_entry(input int dividend, input int divisor, input int hold);
    stim_t e;
    e.dividend = dividend[`DIV_WIDTH-1:0];
    e.divisor  = divisor[`DIV_WIDTH-1:0];
    e.hold     = hold[7:0];
    return e;
  endfunction

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // ==============================
  // stimulus table
  // ==============================

  task automatic load_table();
    stim[0]  = make_entry(100, 7, 0);
    stim[1]  = make_entry(65535, 1, 2);
    stim[2]  = make_entry(3, 10, 0);
    stim[3]  = make_entry(1234, 0, 1);
    stim[4]  = make_entry(65535, 65535, 0);
    stim[5]  = make_entry(0, 5, 3);
    stim[6]  = make_entry(50000, 123, 0);
    stim[7]  = make_entry(0, 0, 1);
    // these four keep their credits long enough to stall the engine.
    stim[8]  = make_entry(40000, 3, 150);
    stim[9]  = make_entry(777, 777, 150);
    stim[10] = make_entry(65535, 2, 150);
    stim[11] = make_entry(9, 4, 150);
    stim[12] = make_entry(32768, 256, 0);
    stim[13] = make_entry(12345, 0, 2);
    stim[14] = make_entry(1, 65535, 0);
    stim[15] = make_entry(60001, 17, 1);
    for (int i = 0; i < N; i++) begin
      if (stim[i].divisor == '0) begin
        exp_q[i]  = '1;
        exp_r[i]  = stim[i].dividend;
        exp_dz[i] = 1'b1;
      end else begin
        exp_q[i]  = stim[i].dividend / stim[i].divisor;
        exp_r[i]  = stim[i].dividend % stim[i].divisor;
        exp_dz[i] = 1'b0;
      end
    end
  endtask

  // ==============================
  // response monitor and credit model
  // ==============================

  // outputs are sampled mid-cycle, away from the edge that updates them.
  always @(negedge clk) begin
    if (rstn) begin
      if (req_credit) begin
        up_returned++;
        check_val("upstream credit not above sent", 1, up_returned <= sent);
      end
      if (rsp_valid) begin
        if (rcvd >= N) begin
          errors++;
          $display("an extra response arrived after all %0d were received", N);
        end else begin
          check_val("downstream credit limit", 1, (rcvd - dn_returned) < `DIV_RSP_DEPTH);
          check_val($sformatf("entry %0d quotient", rcvd), exp_q[rcvd], rsp.quotient);
          check_val($sformatf("entry %0d remainder", rcvd), exp_r[rcvd], rsp.remainder);
          check_val($sformatf("entry %0d dz", rcvd), exp_dz[rcvd], rsp.dz);
          check_val($sformatf("entry %0d id", rcvd), rcvd % (1 << `DIV_ID_W), rsp.id);
          rng_cred = lcg_step(rng_cred);
          due_q.push_back(cycle + stim[rcvd].hold + rng_cred[17:16]);
          rcvd++;
        end
      end
      // the engine takes this credit at the coming rising edge.
      if (rsp_credit) begin
        dn_returned++;
      end
    end
  end

  always @(posedge clk) begin
    int found;
    cycle = cycle + 1;
    if (cycle >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
    if (rstn) begin
      found = -1;
      for (int i = 0; i < due_q.size(); i++) begin
        if (found < 0 && due_q[i] <= cycle) begin
          found = i;
        end
      end
      if (found >= 0) begin
        due_q.delete(found);
        rsp_credit <= 1'b1;
      end else begin
        rsp_credit <= 1'b0;
      end
    end
  end

  // ==============================
  // main sequence
  // ==============================

  initial begin
    rstn        = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    rsp_credit  = 1'b0;
    errors      = 0;
    sent        = 0;
    up_returned = 0;
    rcvd        = 0;
    dn_returned = 0;
    cycle       = 0;
    gap         = 0;
    rng_send    = SEED;
    rng_cred    = SEED;
    load_table();

    repeat (2) @(posedge clk);
    rstn <= 1'b1;

    repeat (4) begin
      @(negedge clk);
      check_val("idle req_credit", 0, req_credit);
      check_val("idle rsp_valid", 0, rsp_valid);
    end

    // the sender spends one credit per request and waits a random gap.
    while (sent < N) begin
      @(posedge clk);
      req_valid <= 1'b0;
      if (gap > 0) begin
        gap--;
      end else if ((sent - up_returned) < `DIV_REQ_DEPTH) begin
        req_valid    <= 1'b1;
        req.dividend <= stim[sent].dividend;
        req.divisor  <= stim[sent].divisor;
        req.id       <= sent[`DIV_ID_W-1:0];
        sent++;
        rng_send = lcg_step(rng_send);
        gap      = rng_send[17:16];
      end
    end
    @(posedge clk);
    req_valid <= 1'b0;

    while (rcvd < N || due_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);

    check_val("request credits returned", N, up_returned);
    $display("errors: %0d, responses: %0d of %0d, request credits: %0d",
             errors, rcvd, N, up_returned);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
